// ==== Bender.yml ====
package:
  name: s1c88_core

sources:
  - src/s1c88_pkg.sv
  - src/opcode_decoder.sv
  - src/data_path.sv
  - src/bus_sequencer.sv
  - src/s1c88_core.sv
  - target: test
    files:
      - test/bus_memory.sv
      - test/s1c88_core_tb.sv

// ==== list.f ====
src/s1c88_pkg.sv
src/opcode_decoder.sv
src/data_path.sv
src/bus_sequencer.sv
src/s1c88_core.sv
test/bus_memory.sv
test/s1c88_core_tb.sv

// ==== test/s1c88_core_tb.sv ====
module s1c88_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_wait = 3;
    localparam int max_cycles = 4000;

    logic                   clk;
    logic                   reset;
    logic                   clear;
    s1c88_pkg::byte_t       data_in;
    logic                   pk;
    logic                   pl;
    s1c88_pkg::addr_t       address_out;
    s1c88_pkg::byte_t       data_out;
    s1c88_pkg::bus_status_t bus_status;
    logic                   read;
    logic                   write;
    logic                   sync;
    logic                   iack;
    int                     seed;

    // program image that the next test loads at its vector
    s1c88_pkg::byte_t prog [0:255];
    int               prog_len;

    // one entry per bus cycle, taken in the pk clock
    s1c88_pkg::addr_t       log_addr [0:1023];
    s1c88_pkg::bus_status_t log_status [0:1023];
    logic                   log_sync [0:1023];
    logic                   log_iack [0:1023];
    int                     log_count;
    logic                   started;
    s1c88_pkg::addr_t       pk_addr;
    s1c88_pkg::bus_status_t pk_status;
    logic                   pk_sync;

    s1c88_core #(
        .reset_wait_cycles (reset_wait)
    ) s1c88_core_i (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .pk          (pk),
        .pl          (pl),
        .address_out (address_out),
        .data_out    (data_out),
        .bus_status  (bus_status),
        .read        (read),
        .write       (write),
        .sync        (sync),
        .iack        (iack)
    );

    bus_memory mem_i (
        .clk         (clk),
        .pk          (pk),
        .pl          (pl),
        .read        (read),
        .write       (write),
        .clear       (clear),
        .address_out (address_out),
        .data_out    (data_out),
        .data_in     (data_in)
    );

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("Fail at %0d ns: %s, got %0h, expected %0h", $time, what, got, expected);
            stop_run();
        end
    endtask

    // bus protocol watch, runs through every test
    always @(posedge clk)
    begin
        if (reset)
        begin
            log_count <= 0;
            started   <= 1'b0;
        end
        else
        begin
            if (started)
                check_value("pk and pl alternate", pk ^ pl, 1);
            if (pk)
            begin
                started <= 1'b1;
                check_value("write in a pk clock", write, 0);
                check_value("upper address byte", address_out[23:16], 0);
                check_value("read in a pk clock", read, bus_status != s1c88_pkg::bus_mem_write);
                if (log_count < 1024)
                begin
                    log_addr[log_count]   <= address_out;
                    log_status[log_count] <= bus_status;
                    log_sync[log_count]   <= sync;
                    log_iack[log_count]   <= iack;
                end
                log_count <= log_count + 1;
                pk_addr   <= address_out;
                pk_status <= bus_status;
                pk_sync   <= sync;
            end
            if (pl)
            begin
                check_value("read in a pl clock", read, 0);
                check_value("address held through pl", address_out, pk_addr);
                check_value("bus status held through pl", bus_status, pk_status);
                check_value("sync held through pl", sync, pk_sync);
            end
        end
    end

    task automatic add_byte(input s1c88_pkg::byte_t value);
        prog[prog_len] = value;
        prog_len++;
    endtask

    // holds the core in reset, loads the program and lets it run
    task automatic start_program(input s1c88_pkg::word_t vector);
        int idle;
        reset <= 1'b1;
        clear <= 1'b1;
        repeat (8)
            @(posedge clk);
        check_value("pk in reset", pk, 0);
        check_value("pl in reset", pl, 0);
        check_value("read in reset", read, 0);
        check_value("write in reset", write, 0);
        check_value("sync in reset", sync, 0);
        check_value("iack in reset", iack, 0);
        check_value("bus status in reset", bus_status, s1c88_pkg::bus_idle);
        check_value("address in reset", address_out, 24'hFFFFFF);
        check_value("data out in reset", data_out, 0);
        mem_i.fill_memory();
        mem_i.load_byte(16'h0000, vector[7:0]);
        mem_i.load_byte(16'h0001, vector[15:8]);
        for (int i = 0; i < prog_len; i++)
            mem_i.load_byte(vector + 16'(i), prog[i]);
        // a run of NOPs keeps the core quiet after the program
        for (int i = 0; i < 16; i++)
            mem_i.load_byte(vector + 16'(prog_len + i), s1c88_pkg::opc_nop);
        reset <= 1'b0;
        clear <= 1'b0;
        idle = 0;
        @(posedge clk);
        while (!pk && idle < max_cycles)
        begin
            idle++;
            @(posedge clk);
        end
        if (!pk)
        begin
            $display("timeout: no bus cycle started within %0d clocks after reset", idle);
            stop_run();
        end
        check_value("idle clocks after reset", idle, reset_wait);
    endtask

    task automatic wait_for_writes(input int count);
        int cycles;
        cycles = 0;
        while (mem_i.wr_count < count && cycles < max_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        if (mem_i.wr_count < count)
        begin
            $display("timeout: saw %0d of %0d writes in %0d clocks", mem_i.wr_count, count, cycles);
            stop_run();
        end
    endtask

    task automatic wait_for_bus_cycles(input int count);
        int cycles;
        cycles = 0;
        while (log_count < count && cycles < max_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        if (log_count < count)
        begin
            $display("timeout: saw %0d of %0d bus cycles in %0d clocks", log_count, count, cycles);
            stop_run();
        end
    endtask

    // bytes that an instruction occupies in the program
    function automatic int instr_length(input s1c88_pkg::byte_t opc);
        case (opc)
            8'hC5:
                return 3;
            8'hB0, 8'hB1, 8'h02, 8'h12, 8'h22, 8'h2A:
                return 2;
            default:
                return 1;
        endcase
    endfunction

    function automatic s1c88_pkg::byte_t alu_model(input s1c88_pkg::byte_t opc,
                                                   input s1c88_pkg::byte_t a,
                                                   input s1c88_pkg::byte_t b);
        case (opc)
            8'h02:
                return 8'((a + b) % 256);
            8'h12:
                return 8'((256 + a - b) % 256);
            8'h22:
                return a & b;
            default:
                return a | b;
        endcase
    endfunction

    task automatic test_reset_vector();
        s1c88_pkg::word_t vector;
        vector = {4'h1, 12'($random(seed))};
        prog_len = 0;
        add_byte(s1c88_pkg::opc_nop);
        add_byte(s1c88_pkg::opc_nop);
        start_program(vector);
        wait_for_bus_cycles(3);
        check_value("first vector address", log_addr[0], 24'h000000);
        check_value("second vector address", log_addr[1], 24'h000001);
        check_value("first vector iack", log_iack[0], 1);
        check_value("second vector iack", log_iack[1], 1);
        check_value("vector read status", log_status[0], s1c88_pkg::bus_irq_read);
        check_value("second vector read status", log_status[1], s1c88_pkg::bus_irq_read);
        check_value("vector sync", log_sync[0], 0);
        check_value("first fetch address", log_addr[2], {8'h00, vector});
        check_value("first fetch sync", log_sync[2], 1);
        check_value("first fetch iack", log_iack[2], 0);
        check_value("first fetch status", log_status[2], s1c88_pkg::bus_mem_read);
    endtask

    task automatic test_load_store();
        s1c88_pkg::word_t hl;
        s1c88_pkg::byte_t value;
        hl       = 16'h8000 | 16'($random(seed));
        value    = 8'($random(seed));
        prog_len = 0;
        add_byte(s1c88_pkg::opc_ld_hl_imm);
        add_byte(hl[7:0]);
        add_byte(hl[15:8]);
        add_byte(s1c88_pkg::opc_ld_a_imm);
        add_byte(value);
        add_byte(s1c88_pkg::opc_ld_ind_hl_a);
        start_program(16'h0200);
        wait_for_writes(1);
        check_value("store address", mem_i.wr_addr[0], {8'h00, hl});
        check_value("store data", mem_i.wr_data[0], value);
        // cycle 8 follows two vector reads and six program bytes
        check_value("write cycle status", log_status[8], s1c88_pkg::bus_mem_write);
        check_value("write cycle address", log_addr[8], {8'h00, hl});
    endtask

    task automatic test_alu();
        s1c88_pkg::byte_t ops [0:5];
        s1c88_pkg::byte_t lhs [0:5];
        s1c88_pkg::byte_t rhs [0:5];
        ops = '{8'h02, 8'h02, 8'h12, 8'h12, 8'h22, 8'h2A};
        // a carry out and a borrow among the pairs
        lhs = '{8'hF0, 8'h12, 8'h10, 8'h80, 8'h5C, 8'h81};
        rhs = '{8'h25, 8'h34, 8'h30, 8'h01, 8'h3A, 8'h14};
        prog_len = 0;
        add_byte(s1c88_pkg::opc_ld_hl_imm);
        add_byte(8'h00);
        add_byte(8'h90);
        for (int i = 0; i < 6; i++)
        begin
            add_byte(s1c88_pkg::opc_ld_a_imm);
            add_byte(lhs[i]);
            add_byte(ops[i]);
            add_byte(rhs[i]);
            add_byte(s1c88_pkg::opc_ld_ind_hl_a);
        end
        start_program(16'h0300);
        wait_for_writes(6);
        for (int i = 0; i < 6; i++)
        begin
            check_value("alu store address", mem_i.wr_addr[i], 24'h009000);
            check_value("alu result", mem_i.wr_data[i], alu_model(ops[i], lhs[i], rhs[i]));
        end
    endtask

    task automatic test_fetch_sequence();
        s1c88_pkg::byte_t or_value;
        int               pos;
        or_value = 8'($random(seed));
        prog_len = 0;
        add_byte(s1c88_pkg::opc_nop);
        add_byte(s1c88_pkg::opc_ld_b_imm);
        add_byte(8'h3C);
        add_byte(s1c88_pkg::opc_ld_hl_imm);
        add_byte(8'h40);
        add_byte(8'hA0);
        add_byte(8'h55);
        add_byte(s1c88_pkg::opc_ld_ind_hl_a);
        add_byte(8'h9C);
        add_byte(s1c88_pkg::opc_or_a_imm);
        add_byte(or_value);
        add_byte(s1c88_pkg::opc_ld_ind_hl_a);
        start_program(16'h0480);
        wait_for_writes(2);
        pos = 0;
        for (int i = 2; i < log_count && pos < prog_len; i++)
        begin
            if (log_sync[i])
            begin
                check_value("fetch address", log_addr[i], 24'h000480 + pos);
                pos += instr_length(prog[pos]);
            end
        end
        check_value("fetched program length", pos, prog_len);
        // A is still zero at the first store and B does not touch it
        check_value("first store data", mem_i.wr_data[0], 0);
        check_value("second store data", mem_i.wr_data[1], or_value);
        check_value("second store address", mem_i.wr_addr[1], 24'h00A040);
    endtask

    task automatic test_random_program();
        s1c88_pkg::byte_t kinds [0:6];
        s1c88_pkg::byte_t opc;
        s1c88_pkg::byte_t value;
        s1c88_pkg::byte_t a_ref;
        s1c88_pkg::word_t hl_ref;
        s1c88_pkg::addr_t exp_addr [0:39];
        s1c88_pkg::byte_t exp_data [0:39];
        kinds    = '{8'hB0, 8'hB1, 8'hC5, 8'h02, 8'h12, 8'h22, 8'h2A};
        a_ref    = 8'h00;
        hl_ref   = 16'hC000;
        prog_len = 0;
        add_byte(s1c88_pkg::opc_ld_hl_imm);
        add_byte(hl_ref[7:0]);
        add_byte(hl_ref[15:8]);
        for (int i = 0; i < 40; i++)
        begin
            opc   = kinds[($random(seed) & 32'h7fffffff) % 7];
            value = 8'($random(seed));
            add_byte(opc);
            add_byte(value);
            if (opc == 8'hC5)
            begin
                // keep stores well away from the program
                hl_ref = {8'h80 | 8'($random(seed)), value};
                add_byte(hl_ref[15:8]);
            end
            else if (opc == 8'hB0)
                a_ref = value;
            else if (opc != 8'hB1)
                a_ref = alu_model(opc, a_ref, value);
            add_byte(s1c88_pkg::opc_ld_ind_hl_a);
            exp_addr[i] = {8'h00, hl_ref};
            exp_data[i] = a_ref;
        end
        start_program(16'h0600);
        wait_for_writes(40);
        for (int i = 0; i < 40; i++)
        begin
            check_value("random store address", mem_i.wr_addr[i], exp_addr[i]);
            check_value("random store data", mem_i.wr_data[i], exp_data[i]);
        end
    endtask

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
        clear = 1'b1;
        seed  = 32'ha15b626a;
        test_reset_vector();
        test_load_store();
        test_alu();
        test_fetch_sequence();
        test_random_program();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== test/bus_memory.sv ====
module bus_memory
(
    input  logic             clk,
    input  logic             pk,
    input  logic             pl,
    input  logic             read,
    input  logic             write,
    input  logic             clear,
    input  s1c88_pkg::addr_t address_out,
    input  s1c88_pkg::byte_t data_out,
    output s1c88_pkg::byte_t data_in
);
    timeunit 1ns;
    timeprecision 1ps;

    s1c88_pkg::byte_t mem [0:65535];
    s1c88_pkg::addr_t wr_addr [0:255];
    s1c88_pkg::byte_t wr_data [0:255];
    int               wr_count;

    initial
    begin
        data_in  = '0;
        wr_count = 0;
    end

    always @(posedge clk)
    begin
        if (clear)
            wr_count <= 0;

        // the byte read in the pk clock is held through the pl clock, where the core samples it
        if (pk && read)
            data_in <= mem[address_out[15:0]];
        else
            data_in <= '0;

        if (pl && write)
        begin
            mem[address_out[15:0]] <= data_out;
            if (wr_count < 256)
            begin
                wr_addr[wr_count] <= address_out;
                wr_data[wr_count] <= data_out;
            end
            wr_count <= wr_count + 1;
        end
    end

    // background contents that differ from address to address
    task automatic fill_memory();
        for (int a = 0; a < 65536; a++)
            mem[a] = a[15:8] ^ a[7:0] ^ 8'h5A;
    endtask

    task automatic load_byte(input s1c88_pkg::word_t addr, input s1c88_pkg::byte_t value);
        mem[addr] = value;
    endtask

endmodule

// ==== src/s1c88_core.sv ====
module s1c88_core
#(
    parameter int reset_wait_cycles = 2
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  s1c88_pkg::byte_t       data_in,
    output logic                   pk,
    output logic                   pl,
    output s1c88_pkg::addr_t       address_out,
    output s1c88_pkg::byte_t       data_out,
    output s1c88_pkg::bus_status_t bus_status,
    output logic                   read,
    output logic                   write,
    output logic                   sync,
    output logic                   iack
);

    s1c88_pkg::byte_t    opcode;
    logic                need_imm;
    logic                imm_wide;
    logic                is_store;
    s1c88_pkg::exec_op_t exec_op;
    logic                imm_low_valid;
    logic                imm_high_valid;
    logic                execute;
    s1c88_pkg::word_t    hl;

    bus_sequencer #(
        .reset_wait_cycles (reset_wait_cycles)
    ) bus_sequencer_i (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .need_imm       (need_imm),
        .imm_wide       (imm_wide),
        .is_store       (is_store),
        .hl             (hl),
        .opcode         (opcode),
        .imm_low_valid  (imm_low_valid),
        .imm_high_valid (imm_high_valid),
        .execute        (execute),
        .pk             (pk),
        .pl             (pl),
        .address_out    (address_out),
        .bus_status     (bus_status),
        .read           (read),
        .write          (write),
        .sync           (sync),
        .iack           (iack)
    );

    opcode_decoder opcode_decoder_i (
        .opcode   (opcode),
        .need_imm (need_imm),
        .imm_wide (imm_wide),
        .is_store (is_store),
        .exec_op  (exec_op)
    );

    data_path data_path_i (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .exec_op        (exec_op),
        .imm_low_valid  (imm_low_valid),
        .imm_high_valid (imm_high_valid),
        .execute        (execute),
        .hl             (hl),
        .data_out       (data_out)
    );

endmodule

// ==== src/bus_sequencer.sv ====
module bus_sequencer
#(
    parameter int reset_wait_cycles = 2
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  s1c88_pkg::byte_t       data_in,
    input  logic                   need_imm,
    input  logic                   imm_wide,
    input  logic                   is_store,
    input  s1c88_pkg::word_t       hl,
    output s1c88_pkg::byte_t       opcode,
    output logic                   imm_low_valid,
    output logic                   imm_high_valid,
    output logic                   execute,
    output logic                   pk,
    output logic                   pl,
    output s1c88_pkg::addr_t       address_out,
    output s1c88_pkg::bus_status_t bus_status,
    output logic                   read,
    output logic                   write,
    output logic                   sync,
    output logic                   iack
);

    localparam int wait_w = (reset_wait_cycles > 1) ? $clog2(reset_wait_cycles) : 1;

    s1c88_pkg::seq_state_t state;
    s1c88_pkg::seq_state_t next_state;
    logic [wait_w-1:0]     wait_count;
    logic                  phase;
    s1c88_pkg::word_t      pc;
    s1c88_pkg::byte_t      opcode_q;

    // phase low is the pk clock, phase high is the pl clock
    assign pk = (state != s1c88_pkg::st_wait) && !phase;
    assign pl = (state != s1c88_pkg::st_wait) && phase;

    // during a fetch the decoder looks at the byte arriving on the bus,
    // which lets the state machine branch at the end of that same cycle
    assign opcode = (state == s1c88_pkg::st_fetch) ? data_in : opcode_q;

    assign imm_low_valid  = pl && (state == s1c88_pkg::st_imm_low);
    assign imm_high_valid = pl && (state == s1c88_pkg::st_imm_high);
    assign execute        = pl && (((state == s1c88_pkg::st_imm_low) && !imm_wide) ||
                                   (state == s1c88_pkg::st_imm_high));

    always_comb
    begin
        case (state)
            s1c88_pkg::st_vector_low:
                next_state = s1c88_pkg::st_vector_high;

            s1c88_pkg::st_vector_high:
                next_state = s1c88_pkg::st_fetch;

            s1c88_pkg::st_fetch:
            begin
                if (need_imm)
                    next_state = s1c88_pkg::st_imm_low;
                else if (is_store)
                    next_state = s1c88_pkg::st_write;
                else
                    next_state = s1c88_pkg::st_fetch;
            end

            s1c88_pkg::st_imm_low:
                next_state = imm_wide ? s1c88_pkg::st_imm_high : s1c88_pkg::st_fetch;

            s1c88_pkg::st_imm_high,
            s1c88_pkg::st_write:
                next_state = s1c88_pkg::st_fetch;

            default:
                next_state = s1c88_pkg::st_wait;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= s1c88_pkg::st_wait;
            wait_count <= '0;
            phase      <= 1'b0;
            pc         <= '0;
            opcode_q   <= s1c88_pkg::opc_nop;
        end
        else if (state == s1c88_pkg::st_wait)
        begin
            // idle after reset, then start the reset exception
            wait_count <= wait_count + 1'b1;
            if (wait_count == wait_w'(reset_wait_cycles - 1))
            begin
                state <= s1c88_pkg::st_vector_low;
            end
        end
        else
        begin
            phase <= ~phase;

            // everything below happens at the end of the pl clock
            if (phase)
            begin
                state <= next_state;

                case (state)
                    s1c88_pkg::st_vector_low:
                        pc[7:0] <= data_in;

                    s1c88_pkg::st_vector_high:
                        pc[15:8] <= data_in;

                    s1c88_pkg::st_fetch:
                    begin
                        opcode_q <= data_in;
                        pc       <= pc + 16'd1;
                    end

                    s1c88_pkg::st_imm_low,
                    s1c88_pkg::st_imm_high:
                        pc <= pc + 16'd1;

                    default:
                        pc <= pc;
                endcase
            end
        end
    end

    // address and command only depend on registers that move at pl ends,
    // so they hold for the whole bus cycle
    always_comb
    begin
        case (state)
            s1c88_pkg::st_wait:
            begin
                address_out = '1;
                bus_status  = s1c88_pkg::bus_idle;
            end

            s1c88_pkg::st_vector_low:
            begin
                address_out = 24'h000000;
                bus_status  = s1c88_pkg::bus_irq_read;
            end

            s1c88_pkg::st_vector_high:
            begin
                address_out = 24'h000001;
                bus_status  = s1c88_pkg::bus_irq_read;
            end

            s1c88_pkg::st_write:
            begin
                address_out = {8'h00, hl};
                bus_status  = s1c88_pkg::bus_mem_write;
            end

            default:
            begin
                address_out = {8'h00, pc};
                bus_status  = s1c88_pkg::bus_mem_read;
            end
        endcase
    end

    assign read  = pk && (state != s1c88_pkg::st_write);
    assign write = pl && (state == s1c88_pkg::st_write);
    assign sync  = (state == s1c88_pkg::st_fetch);
    assign iack  = (state == s1c88_pkg::st_vector_low) || (state == s1c88_pkg::st_vector_high);

endmodule

// ==== src/data_path.sv ====
module data_path
(
    input  logic                clk,
    input  logic                reset,
    input  s1c88_pkg::byte_t    data_in,
    input  s1c88_pkg::exec_op_t exec_op,
    input  logic                imm_low_valid,
    input  logic                imm_high_valid,
    input  logic                execute,
    output s1c88_pkg::word_t    hl,
    output s1c88_pkg::byte_t    data_out
);

    // B sits in the upper byte and A in the lower byte of BA
    s1c88_pkg::word_t ba;
    s1c88_pkg::byte_t a;

    // immediate bytes collected during the operand reads
    s1c88_pkg::word_t imm_q;
    s1c88_pkg::word_t imm_cur;

    s1c88_pkg::byte_t alu_result;

    assign a = ba[7:0];

    // the store writes A, so the bus data is simply A
    assign data_out = a;

    // the last operand byte is still on data_in when execute fires,
    // so the byte being strobed bypasses the register
    assign imm_cur[7:0]  = imm_low_valid  ? data_in : imm_q[7:0];
    assign imm_cur[15:8] = imm_high_valid ? data_in : imm_q[15:8];

    always_ff @(posedge clk)
    begin
        if (imm_low_valid)
        begin
            imm_q[7:0] <= data_in;
        end

        if (imm_high_valid)
        begin
            imm_q[15:8] <= data_in;
        end
    end

    // 8-bit ALU, no flags
    // results wrap modulo 256
    always_comb
    begin
        case (exec_op)
            s1c88_pkg::op_add:
                alu_result = a + imm_cur[7:0];

            s1c88_pkg::op_sub:
                alu_result = a - imm_cur[7:0];

            s1c88_pkg::op_and:
                alu_result = a & imm_cur[7:0];

            s1c88_pkg::op_or:
                alu_result = a | imm_cur[7:0];

            default:
                alu_result = a;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ba <= '0;
            hl <= '0;
        end
        else if (execute)
        begin
            case (exec_op)
                s1c88_pkg::op_ld_a:
                    ba[7:0] <= imm_cur[7:0];

                s1c88_pkg::op_ld_b:
                    ba[15:8] <= imm_cur[7:0];

                s1c88_pkg::op_ld_hl:
                    hl <= imm_cur;

                s1c88_pkg::op_add,
                s1c88_pkg::op_sub,
                s1c88_pkg::op_and,
                s1c88_pkg::op_or:
                    ba[7:0] <= alu_result;

                default:
                begin
                    // a NOP leaves every register alone
                    ba <= ba;
                end
            endcase
        end
    end

endmodule

// ==== src/opcode_decoder.sv ====
module opcode_decoder
(
    input  s1c88_pkg::byte_t    opcode,
    output logic                need_imm,
    output logic                imm_wide,
    output logic                is_store,
    output s1c88_pkg::exec_op_t exec_op
);

    // the whole instruction table lives here
    // anything not listed falls through to the defaults and runs as a NOP
    always_comb
    begin
        need_imm = 1'b0;
        imm_wide = 1'b0;
        is_store = 1'b0;
        exec_op  = s1c88_pkg::op_nop;

        case (opcode)
            s1c88_pkg::opc_ld_a_imm:
            begin
                need_imm = 1'b1;
                exec_op  = s1c88_pkg::op_ld_a;
            end

            s1c88_pkg::opc_ld_b_imm:
            begin
                need_imm = 1'b1;
                exec_op  = s1c88_pkg::op_ld_b;
            end

            s1c88_pkg::opc_ld_hl_imm:
            begin
                // two operand bytes, low byte first
                need_imm = 1'b1;
                imm_wide = 1'b1;
                exec_op  = s1c88_pkg::op_ld_hl;
            end

            s1c88_pkg::opc_add_a_imm:
            begin
                need_imm = 1'b1;
                exec_op  = s1c88_pkg::op_add;
            end

            s1c88_pkg::opc_sub_a_imm:
            begin
                need_imm = 1'b1;
                exec_op  = s1c88_pkg::op_sub;
            end

            s1c88_pkg::opc_and_a_imm:
            begin
                need_imm = 1'b1;
                exec_op  = s1c88_pkg::op_and;
            end

            s1c88_pkg::opc_or_a_imm:
            begin
                need_imm = 1'b1;
                exec_op  = s1c88_pkg::op_or;
            end

            s1c88_pkg::opc_ld_ind_hl_a:
            begin
                // the store only needs a write cycle, no register changes
                is_store = 1'b1;
            end

            s1c88_pkg::opc_nop:
            begin
                exec_op = s1c88_pkg::op_nop;
            end

            default:
            begin
                exec_op = s1c88_pkg::op_nop;
            end
        endcase
    end

endmodule

// ==== src/s1c88_pkg.sv ====
package s1c88_pkg;

    // an 8-bit data byte on the bus, also the width of A, B and the opcode
    typedef logic [7:0] byte_t;

    // program counter, HL, BA and the assembled 16-bit immediate
    typedef logic [15:0] word_t;

    // full bus address, the upper byte is always zero in this core
    typedef logic [23:0] addr_t;

    // bus command driven on bus_status for the whole bus cycle
    typedef enum logic [1:0]
    {
        bus_idle      = 2'd0,
        bus_irq_read  = 2'd1,
        bus_mem_write = 2'd2,
        bus_mem_read  = 2'd3
    } bus_status_t;

    // sequencer states, one state per bus cycle except st_wait
    typedef enum logic [2:0]
    {
        st_wait        = 3'd0,
        st_vector_low  = 3'd1,
        st_vector_high = 3'd2,
        st_fetch       = 3'd3,
        st_imm_low     = 3'd4,
        st_imm_high    = 3'd5,
        st_write       = 3'd6
    } seq_state_t;

    // what the data path does when the execute strobe fires
    typedef enum logic [2:0]
    {
        op_nop   = 3'd0,
        op_ld_a  = 3'd1,
        op_ld_b  = 3'd2,
        op_ld_hl = 3'd3,
        op_add   = 3'd4,
        op_sub   = 3'd5,
        op_and   = 3'd6,
        op_or    = 3'd7
    } exec_op_t;

    // opcodes of the supported instruction subset
    localparam byte_t opc_ld_a_imm    = 8'hB0;
    localparam byte_t opc_ld_b_imm    = 8'hB1;
    localparam byte_t opc_ld_hl_imm   = 8'hC5;
    localparam byte_t opc_add_a_imm   = 8'h02;
    localparam byte_t opc_sub_a_imm   = 8'h12;
    localparam byte_t opc_and_a_imm   = 8'h22;
    localparam byte_t opc_or_a_imm    = 8'h2A;
    localparam byte_t opc_ld_ind_hl_a = 8'h78;
    localparam byte_t opc_nop         = 8'hFF;

endpackage
